// File: design/addr_decode.sv
`default_nettype none

`include "cart_defines.svh"

module addr_decode (
  snes_bus_if.dst              bus,
  input  cart_pkg::cart_addr_t rom_mask,
  input  cart_pkg::cart_addr_t saveram_mask,
  output cart_pkg::region_t    region,
  output cart_pkg::cart_addr_t mapped_addr,
  output logic [3:0]           snescmd_idx
);
  import cart_pkg::*;

  localparam cart_addr_t cmd_base  = `SNESCMD_BASE;
  localparam cart_addr_t sram_base = `SAVERAM_BASE;

  logic [7:0]  bank;
  logic [19:0] sram_off;  // 32 KB window per bank, banks 70..7D
  logic [21:0] rom_off;   // LoROM, upper half of each bank

  assign bank     = bus.addr[23:16];
  assign sram_off = {bus.addr[20:16], bus.addr[14:0]};
  assign rom_off  = {bus.addr[22:16], bus.addr[14:0]};

  assign snescmd_idx = bus.addr[3:0];

  // First match wins
  always_comb begin
    region      = rgn_none;
    mapped_addr = '0;
    if (!bus.addr[22] && bus.addr[15:4] == cmd_base[15:4]) begin
      region = rgn_snescmd;  // Served from cmd_regs, not PSRAM
    end else if (bank >= 8'h70 && bank <= 8'h7d && !bus.addr[15]) begin
      region      = rgn_saveram;
      mapped_addr = sram_base + (cart_addr_t'(sram_off) & saveram_mask);
    end else if (bus.addr[15]) begin
      region      = rgn_rom;
      mapped_addr = cart_addr_t'(rom_off) & rom_mask;
    end
  end

endmodule

`default_nettype wire

// File: design/cart_defines.svh
`ifndef CART_DEFINES_SVH
`define CART_DEFINES_SVH

//////////////////////////////
// Bus widths
//////////////////////////////

`define CART_ADDR_W      24  // Console and PSRAM byte address
`define CART_DATA_W      8   // Console data byte
`define PSRAM_WORD_W     16  // PSRAM data word

//////////////////////////////
// PSRAM access delays
//////////////////////////////

// Countdown loads, all fit the 4-bit delay counter
`define ROM_RD_WAIT      4'd4
`define ROM_WR_WAIT1     4'd2  // Before console write data phase
`define ROM_WR_WAIT2     4'd3  // After console write data phase
`define ROM_RD_WAIT_MCU  4'd6
`define ROM_WR_WAIT_MCU  4'd6
`define MCU_TAIL_WAIT    4'd2  // Recovery after a MCU access

//////////////////////////////
// Memory map
//////////////////////////////

`define SAVERAM_BASE     24'hE00000  // In PSRAM
`define SNESCMD_BASE     24'h002A00  // On the console bus

`endif

// File: design/cart_main.sv
`default_nettype none

`include "cart_defines.svh"

module cart_main (
  input  logic                     CLK2,
  input  logic                     rst,
  input  cart_pkg::cart_addr_t     snes_addr,
  input  logic                     snes_read,     // Active low
  input  logic                     snes_write,    // Active low
  input  logic                     snes_cpu_clk,
  input  logic                     snes_cs,
  input  cart_pkg::cart_byte_t     snes_data_in,
  output cart_pkg::cart_byte_t     snes_data_out,
  output logic                     snes_databus_oe,
  output logic                     snes_databus_dir,
  input  cart_pkg::cart_addr_t     rom_mask,
  input  cart_pkg::cart_addr_t     saveram_mask,
  input  cart_pkg::cart_addr_t     mcu_addr,
  input  cart_pkg::cart_byte_t     mcu_dout,
  input  logic                     mcu_rrq,
  input  logic                     mcu_wrq,
  output logic                     mcu_rdy,
  output cart_pkg::cart_byte_t     mcu_data_in,
  output logic [`CART_ADDR_W-2:0]  rom_addr,
  input  logic [`PSRAM_WORD_W-1:0] rom_dq_in,
  output logic [`PSRAM_WORD_W-1:0] rom_dq_out,
  output logic                     rom_dq_oe,
  output logic                     rom_we,
  output logic                     rom_bhe,
  output logic                     rom_ble
);
  import cart_pkg::*;

  snes_bus_if bus ();

  region_t    region;
  cart_addr_t mapped_addr;
  logic [3:0] snescmd_idx;
  cart_byte_t cmd_data;
  cart_byte_t arb_rd_data;
  logic       strobe_active;
  logic       drive_bus;

  snes_bus_sync u_sync (
    .CLK2         (CLK2),
    .snes_addr    (snes_addr),
    .snes_read    (snes_read),
    .snes_write   (snes_write),
    .snes_cpu_clk (snes_cpu_clk),
    .bus          (bus.src)
  );

  addr_decode u_decode (
    .bus          (bus.dst),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask),
    .region       (region),
    .mapped_addr  (mapped_addr),
    .snescmd_idx  (snescmd_idx)
  );

  cmd_regs u_cmd (
    .CLK2     (CLK2),
    .bus      (bus.dst),
    .region   (region),
    .idx      (snescmd_idx),
    .data_in  (snes_data_in),
    .data_out (cmd_data)
  );

  rom_arbiter u_arb (
    .CLK2         (CLK2),
    .rst          (rst),
    .bus          (bus.dst),
    .region       (region),
    .mapped_addr  (mapped_addr),
    .snes_data_in (snes_data_in),
    .snes_rd_data (arb_rd_data),
    .mcu_addr     (mcu_addr),
    .mcu_dout     (mcu_dout),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .mcu_rdy      (mcu_rdy),
    .mcu_data_in  (mcu_data_in),
    .rom_addr     (rom_addr),
    .rom_dq_in    (rom_dq_in),
    .rom_dq_out   (rom_dq_out),
    .rom_dq_oe    (rom_dq_oe),
    .rom_we       (rom_we),
    .rom_bhe      (rom_bhe),
    .rom_ble      (rom_ble)
  );

  //////////////////////////////
  // Console data bus
  //////////////////////////////

  assign snes_data_out = (region == rgn_snescmd) ? cmd_data : arb_rd_data;

  assign strobe_active = ~bus.read_level | ~snes_write;
  assign drive_bus = (region == rgn_snescmd) | (region == rgn_saveram)
                   | ((region == rgn_rom) & snes_cs);

  // Transceiver enable, active low
  assign snes_databus_oe  = ~(strobe_active & drive_bus);
  assign snes_databus_dir = ~bus.read_level;  // High drives toward the console

endmodule

`default_nettype wire

// File: design/cart_pkg.sv
`default_nettype none

`include "cart_defines.svh"

package cart_pkg;

  // Byte address, console side and PSRAM side alike
  typedef logic [`CART_ADDR_W-1:0] cart_addr_t;

  typedef logic [`CART_DATA_W-1:0] cart_byte_t;

  // Result of the address decode
  typedef enum logic [1:0] {
    rgn_none,
    rgn_rom,
    rgn_saveram,
    rgn_snescmd
  } region_t;

  // PSRAM arbiter states
  typedef enum logic [4:0] {
    st_idle,
    st_snes_rd_addr,
    st_snes_rd_wait,
    st_snes_rd_end,
    st_snes_wr_addr,
    st_snes_wr_wait1,
    st_snes_wr_data,
    st_snes_wr_wait2,
    st_snes_wr_end,
    st_mcu_rd_addr,
    st_mcu_rd_wait,
    st_mcu_rd_wait2,
    st_mcu_rd_end,
    st_mcu_wr_addr,
    st_mcu_wr_wait,
    st_mcu_wr_wait2,
    st_mcu_wr_end
  } arb_state_t;

endpackage

`default_nettype wire

// File: design/cmd_regs.sv
`default_nettype none

module cmd_regs (
  input  logic                 CLK2,
  snes_bus_if.dst              bus,
  input  cart_pkg::region_t    region,
  input  logic [3:0]           idx,
  input  cart_pkg::cart_byte_t data_in,
  output cart_pkg::cart_byte_t data_out
);
  import cart_pkg::*;

  cart_byte_t regs [0:15];

  // Console data is stable by the /WR rise
  always_ff @(posedge CLK2) begin
    if (bus.wr_end && region == rgn_snescmd) begin
      regs[idx] <= data_in;
    end
  end

  assign data_out = regs[idx];  // Async read back

endmodule

`default_nettype wire

// File: design/rom_arbiter.sv
`default_nettype none

`include "cart_defines.svh"

module rom_arbiter (
  input  logic                     CLK2,
  input  logic                     rst,
  snes_bus_if.dst                  bus,
  input  cart_pkg::region_t        region,
  input  cart_pkg::cart_addr_t     mapped_addr,
  input  cart_pkg::cart_byte_t     snes_data_in,
  output cart_pkg::cart_byte_t     snes_rd_data,
  input  cart_pkg::cart_addr_t     mcu_addr,
  input  cart_pkg::cart_byte_t     mcu_dout,
  input  logic                     mcu_rrq,
  input  logic                     mcu_wrq,
  output logic                     mcu_rdy,
  output cart_pkg::cart_byte_t     mcu_data_in,
  output logic [`CART_ADDR_W-2:0]  rom_addr,
  input  logic [`PSRAM_WORD_W-1:0] rom_dq_in,
  output logic [`PSRAM_WORD_W-1:0] rom_dq_out,
  output logic                     rom_dq_oe,
  output logic                     rom_we,
  output logic                     rom_bhe,
  output logic                     rom_ble
);
  import cart_pkg::*;

  arb_state_t state;
  logic [3:0] delay_r;
  logic       delay_done;
  logic       mcu_rd_pend;
  logic       mcu_wr_pend;
  logic       need_snes_addr;
  logic       is_cart;
  logic       assert_snes_addr;
  cart_addr_t addr_r;      // Latched access address
  cart_addr_t psram_addr;
  cart_byte_t wdata_r;
  cart_byte_t lane_byte;

  assign is_cart    = (region == rgn_rom) || (region == rgn_saveram);
  assign delay_done = (delay_r == 4'd0);

  //////////////////////////////
  // PSRAM address and lanes
  //////////////////////////////

  // Console address is set until its access has been served
  always_ff @(posedge CLK2) begin
    if (rst) begin
      need_snes_addr <= 1'b0;
    end else if (bus.cycle_end) begin
      need_snes_addr <= 1'b1;
    end else if (state == st_snes_rd_end || state == st_snes_wr_end) begin
      need_snes_addr <= 1'b0;
    end
  end

  assign assert_snes_addr = bus.cpu_clk_level & need_snes_addr & is_cart;
  assign psram_addr       = assert_snes_addr ? mapped_addr : addr_r;

  assign rom_addr = psram_addr[`CART_ADDR_W-1:1];
  assign rom_bhe  = psram_addr[0];   // Odd address is the low byte
  assign rom_ble  = ~psram_addr[0];

  assign lane_byte  = psram_addr[0] ? rom_dq_in[7:0] : rom_dq_in[15:8];
  assign rom_dq_out = psram_addr[0] ? {8'h00, wdata_r} : {wdata_r, 8'h00};
  assign rom_dq_oe  = ~rom_we;

  //////////////////////////////
  // MCU request tracking
  //////////////////////////////

  always_ff @(posedge CLK2) begin
    if (rst) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b0;
      mcu_rdy     <= 1'b1;
    end else if (mcu_rrq) begin
      mcu_rd_pend <= 1'b1;
      mcu_rdy     <= 1'b0;
    end else if (mcu_wrq) begin
      mcu_wr_pend <= 1'b1;
      mcu_rdy     <= 1'b0;
    end else if (state == st_mcu_rd_end || state == st_mcu_wr_end) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b0;
      mcu_rdy     <= 1'b1;
    end
  end

  //////////////////////////////
  // Arbiter FSM
  //////////////////////////////

  // Console cycles preempt whatever runs; MCU pending flags survive
  always_ff @(posedge CLK2) begin
    if (rst) begin
      state   <= st_idle;
      delay_r <= 4'd0;
      rom_we  <= 1'b1;
    end else if (bus.cycle_start && is_cart) begin
      state  <= st_snes_rd_addr;
      addr_r <= mapped_addr;
    end else if (bus.wr_start && is_cart) begin
      state  <= st_snes_wr_addr;
      addr_r <= mapped_addr;
    end else begin
      case (state)
        st_idle: begin
          addr_r <= mapped_addr;
          if (!assert_snes_addr) begin
            if (mcu_rd_pend) state <= st_mcu_rd_addr;
            else if (mcu_wr_pend) state <= st_mcu_wr_addr;
          end
        end

        // Console read
        st_snes_rd_addr: begin
          rom_we  <= 1'b1;  // An MCU write may have been cut off
          delay_r <= `ROM_RD_WAIT;
          state   <= st_snes_rd_wait;
        end
        st_snes_rd_wait: begin
          delay_r      <= delay_r - 4'd1;
          snes_rd_data <= lane_byte;
          if (delay_done) state <= st_snes_rd_end;
        end
        st_snes_rd_end: begin
          snes_rd_data <= lane_byte;
          state        <= st_idle;
        end

        // Console write, only save-RAM is writable
        st_snes_wr_addr: begin
          rom_we  <= (region != rgn_saveram);
          delay_r <= `ROM_WR_WAIT1;
          state   <= st_snes_wr_wait1;
        end
        st_snes_wr_wait1: begin
          delay_r <= delay_r - 4'd1;
          if (delay_done) state <= st_snes_wr_data;
        end
        st_snes_wr_data: begin
          wdata_r <= snes_data_in;
          delay_r <= `ROM_WR_WAIT2;
          state   <= st_snes_wr_wait2;
        end
        st_snes_wr_wait2: begin
          delay_r <= delay_r - 4'd1;
          if (delay_done) state <= st_snes_wr_end;
        end
        st_snes_wr_end: begin
          rom_we <= 1'b1;
          state  <= st_idle;
        end

        // MCU read
        st_mcu_rd_addr: begin
          addr_r  <= mcu_addr;
          delay_r <= `ROM_RD_WAIT_MCU;
          state   <= st_mcu_rd_wait;
        end
        st_mcu_rd_wait: begin
          delay_r <= delay_r - 4'd1;
          if (delay_done) begin
            mcu_data_in <= lane_byte;
            delay_r     <= `MCU_TAIL_WAIT;
            state       <= st_mcu_rd_wait2;
          end
        end
        st_mcu_rd_wait2: begin
          delay_r <= delay_r - 4'd1;
          if (delay_done) state <= st_mcu_rd_end;
        end
        st_mcu_rd_end: state <= st_idle;

        // MCU write
        st_mcu_wr_addr: begin
          addr_r  <= mcu_addr;
          wdata_r <= mcu_dout;
          rom_we  <= 1'b0;
          delay_r <= `ROM_WR_WAIT_MCU;
          state   <= st_mcu_wr_wait;
        end
        st_mcu_wr_wait: begin
          delay_r <= delay_r - 4'd1;
          if (delay_done) begin
            rom_we  <= 1'b1;
            delay_r <= `MCU_TAIL_WAIT;
            state   <= st_mcu_wr_wait2;
          end
        end
        st_mcu_wr_wait2: begin
          delay_r <= delay_r - 4'd1;
          if (delay_done) state <= st_mcu_wr_end;
        end
        st_mcu_wr_end: state <= st_idle;

        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/snes_bus_if.sv
`default_nettype none

interface snes_bus_if;
  import cart_pkg::*;

  cart_addr_t addr;           // Resynchronized console address
  logic       cpu_clk_level;  // Raw CPU clock
  logic       read_level;     // Registered /RD
  logic       cycle_start;    // CPU clock rise
  logic       cycle_end;      // CPU clock fall
  logic       wr_start;       // /WR fall
  logic       wr_end;         // /WR rise

  modport src (
    output addr, cpu_clk_level, read_level,
    output cycle_start, cycle_end, wr_start, wr_end
  );

  modport dst (
    input addr, cpu_clk_level, read_level,
    input cycle_start, cycle_end, wr_start, wr_end
  );

endinterface

`default_nettype wire

// File: design/snes_bus_sync.sv
`default_nettype none

module snes_bus_sync (
  input  logic                 CLK2,
  input  cart_pkg::cart_addr_t snes_addr,
  input  logic                 snes_read,
  input  logic                 snes_write,
  input  logic                 snes_cpu_clk,
  snes_bus_if.src              bus
);
  import cart_pkg::*;

  cart_addr_t addr_r [0:2];
  logic [7:0] read_sr;
  logic [7:0] write_sr;
  logic [7:0] cpu_clk_sr;

  // Old level in bit 7, seven matching new samples below it.
  // A single glitch cycle breaks the pattern and yields no event.
  function automatic logic rose(input logic [7:0] sr);
    return sr == 8'b0111_1111;
  endfunction

  function automatic logic fell(input logic [7:0] sr);
    return sr == 8'b1000_0000;
  endfunction

  //////////////////////////////
  // Address resync
  //////////////////////////////

  always_ff @(posedge CLK2) begin
    addr_r[0] <= snes_addr;
    addr_r[1] <= addr_r[0];
    addr_r[2] <= addr_r[1];
  end

  // Bits must agree in two stages before they go high
  assign bus.addr = addr_r[2] & addr_r[1];

  //////////////////////////////
  // Strobe edge detect
  //////////////////////////////

  always_ff @(posedge CLK2) begin
    read_sr    <= {read_sr[6:0], snes_read};
    write_sr   <= {write_sr[6:0], snes_write};
    cpu_clk_sr <= {cpu_clk_sr[6:0], snes_cpu_clk};
  end

  assign bus.cpu_clk_level = snes_cpu_clk;  // Used unfiltered for address steering
  assign bus.read_level    = read_sr[0];

  assign bus.cycle_start = rose(cpu_clk_sr);
  assign bus.cycle_end   = fell(cpu_clk_sr);
  assign bus.wr_start    = fell(write_sr);  // /WR is active low
  assign bus.wr_end      = rose(write_sr);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the cartridge controller simulation with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f vlog.f \
    --top-module tb_cart_main --Mdir obj_dir -o sim_tb; then
  echo "Verilator build failed"
  exit 1
fi

if ! output="$(./obj_dir/sim_tb)"; then
  echo "$output"
  echo "Simulation exited with an error"
  exit 1
fi
echo "$output"

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
exit 1

// File: test/psram_model.sv
`default_nettype none

`include "cart_defines.svh"

module psram_model (
  input  logic                     CLK2,
  input  logic [`CART_ADDR_W-2:0]  addr,   // Word address
  input  logic [`PSRAM_WORD_W-1:0] wdata,
  output logic [`PSRAM_WORD_W-1:0] rdata,
  input  logic                     we,     // Active low
  input  logic                     bhe,    // Active low, upper lane
  input  logic                     ble     // Active low, lower lane
);
  localparam int WORDS = 1 << (`CART_ADDR_W - 1);

  logic [`PSRAM_WORD_W-1:0] mem [0:WORDS-1];

  // Power-up content, every address bit feeds the word
  function automatic logic [15:0] pattern(input logic [22:0] a);
    return a[15:0] ^ {a[22:16], a[22:14]};
  endfunction

  initial begin
    for (int i = 0; i < WORDS; i++) begin
      mem[i[22:0]] = pattern(i[22:0]);
    end
  end

  // Write strobe sampled mid-cycle, away from the DUT clock edge
  always @(negedge CLK2) begin
    if (!we) begin
      if (!ble) mem[addr][7:0] = wdata[7:0];
      if (!bhe) mem[addr][15:8] = wdata[15:8];
    end
  end

  assign rdata = mem[addr];  // Async read

endmodule

`default_nettype wire

// File: test/tb_cart_main.sv
`default_nettype none

`include "cart_defines.svh"

module tb_cart_main;
  import cart_pkg::*;

  localparam int TIMEOUT = 200;  // Cycles per wait loop

  logic                     CLK2;
  logic                     rst;
  cart_addr_t               snes_addr;
  logic                     snes_read;
  logic                     snes_write;
  logic                     snes_cpu_clk;
  logic                     snes_cs;
  cart_byte_t               snes_data_in;
  cart_byte_t               snes_data_out;
  logic                     snes_databus_oe;
  logic                     snes_databus_dir;
  cart_addr_t               rom_mask;
  cart_addr_t               saveram_mask;
  cart_addr_t               mcu_addr;
  cart_byte_t               mcu_dout;
  logic                     mcu_rrq;
  logic                     mcu_wrq;
  logic                     mcu_rdy;
  cart_byte_t               mcu_data_in;
  logic [`CART_ADDR_W-2:0]  rom_addr;
  logic [`PSRAM_WORD_W-1:0] rom_dq_in;
  logic [`PSRAM_WORD_W-1:0] rom_dq_out;
  logic                     rom_dq_oe;
  logic                     rom_we;
  logic                     rom_bhe;
  logic                     rom_ble;

  int   tests;
  int   checks;
  int   errors;
  int   test_errors;
  int   we_low_cycles;  // PSRAM write activity
  logic timed_out;

  initial begin
    CLK2 = 1'b0;
    forever #2 CLK2 = ~CLK2;
  end

  cart_main uut (.*);

  psram_model model (
    .CLK2  (CLK2),
    .addr  (rom_addr),
    .wdata (rom_dq_out),
    .rdata (rom_dq_in),
    .we    (rom_we),
    .bhe   (rom_bhe),
    .ble   (rom_ble)
  );

  always @(posedge CLK2) begin
    if (rst) we_low_cycles <= 0;
    else if (!rom_we) we_low_cycles <= we_low_cycles + 1;
  end

  // The controller drives the PSRAM data bus only while it writes
  always @(negedge CLK2) begin
    if (!rst) begin
      check_value("psram dq_oe", 32'(!rom_we), 32'(rom_dq_oe));
    end
  end

  // Ends the run when a wait loop gives up
  initial begin
    wait (timed_out === 1'b1);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic next_edge();  // Drive point
    @(posedge CLK2);
    #1;
  endtask

  task automatic sample_point();  // Late in the cycle once outputs settle
    @(negedge CLK2);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual == expected) else begin
      errors++;
      test_errors++;
      $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Gave up after %0d cycles waiting for %s", TIMEOUT, what);
    errors++;
    timed_out = 1'b1;
  endtask

  task automatic finish_test(input string name);
    $display("test %s: %0d error(s)", name, test_errors);
    tests++;
    test_errors = 0;
  endtask

  // Odd address on the low lane
  function automatic cart_byte_t model_byte(input cart_addr_t a);
    logic [15:0] word;
    word = model.mem[a[23:1]];
    return a[0] ? word[7:0] : word[15:8];
  endfunction

  task automatic wait_mcu_rdy();
    int cycles;
    cycles = 0;
    while (!mcu_rdy && cycles < TIMEOUT) begin
      sample_point();
      cycles++;
    end
    if (!mcu_rdy) report_timeout("mcu_rdy to rise");
  endtask

  task automatic wait_we_high();
    int cycles;
    cycles = 0;
    while (!rom_we && cycles < TIMEOUT) begin
      sample_point();
      cycles++;
    end
    if (!rom_we) report_timeout("the PSRAM write to end");
  endtask

  task automatic mcu_access(input logic write, input cart_addr_t a,
                            input cart_byte_t data, output cart_byte_t rdata);
    next_edge();
    mcu_addr = a;  // Held until the access ends
    mcu_dout = data;
    mcu_wrq  = write;
    mcu_rrq  = !write;
    next_edge();
    mcu_wrq = 1'b0;
    mcu_rrq = 1'b0;
    sample_point();
    check_value(write ? "mcu write busy" : "mcu read busy", 32'(1'b0), 32'(mcu_rdy));
    wait_mcu_rdy();
    rdata = mcu_data_in;
  endtask

  // One console bus cycle with the strobe in the clock high phase
  task automatic console_cycle(input cart_addr_t a, input logic write,
                               input cart_byte_t wdata, output cart_byte_t rdata,
                               output logic oe, output logic dir);
    next_edge();
    snes_addr    = a;
    snes_cs      = a[15];  // ROM select for the upper half of a bank
    snes_cpu_clk = 1'b0;
    repeat (5) next_edge();  // Address sync
    snes_cpu_clk = 1'b1;
    if (write) begin
      repeat (2) next_edge();  // /WR after the cycle start event
      snes_write   = 1'b0;
      snes_data_in = wdata;
    end else begin
      snes_read = 1'b0;
    end
    repeat (20) next_edge();  // Edge filter plus access time
    sample_point();
    rdata = snes_data_out;
    oe    = snes_databus_oe;
    dir   = snes_databus_dir;
    next_edge();
    snes_read    = 1'b1;
    snes_write   = 1'b1;
    snes_cpu_clk = 1'b0;
    repeat (12) next_edge();  // Lets wr_end and cycle_end fire
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin : main
    cart_addr_t a;
    cart_addr_t target;
    cart_byte_t val;
    cart_byte_t got;
    cart_byte_t partner;
    logic       oe;
    logic       dir;
    int         we_before;
    cart_byte_t cmd_exp [0:15];

    void'($urandom(78));
    tests = 0;
    checks = 0;
    errors = 0;
    test_errors = 0;
    timed_out = 1'b0;
    rst = 1'b1;
    snes_addr = '0;
    snes_read = 1'b1;
    snes_write = 1'b1;
    snes_cpu_clk = 1'b0;
    snes_cs = 1'b0;
    snes_data_in = '0;
    rom_mask = 24'h3FFFFF;
    saveram_mask = 24'h001FFF;
    mcu_addr = '0;
    mcu_dout = '0;
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;

    repeat (8) @(posedge CLK2);
    #1 rst = 1'b0;
    sample_point();
    check_value("reset mcu_rdy", 32'(1'b1), 32'(mcu_rdy));
    check_value("reset rom_we", 32'(1'b1), 32'(rom_we));
    check_value("reset databus_oe", 32'(1'b1), 32'(snes_databus_oe));
    finish_test("reset");

    // MCU write and read back of the same byte
    a = cart_addr_t'($urandom);
    val = cart_byte_t'($urandom);
    partner = model_byte(a ^ 24'h1);
    mcu_access(1'b1, a, val, got);
    check_value("mcu write model byte", 32'(val), 32'(model_byte(a)));
    check_value("mcu write other lane", 32'(partner), 32'(model_byte(a ^ 24'h1)));
    mcu_access(1'b0, a, 8'h00, got);
    check_value("mcu read data", 32'(val), 32'(got));
    finish_test("mcu_rw");

    // LoROM read in bank 00
    a = {8'h00, 1'b1, 15'($urandom)};
    target = cart_addr_t'({a[22:16], a[14:0]}) & rom_mask;
    val = cart_byte_t'($urandom);
    mcu_access(1'b1, target, val, got);  // Preload
    console_cycle(a, 1'b0, 8'h00, got, oe, dir);
    check_value("rom read data", 32'(val), 32'(got));
    check_value("rom read model", 32'(model_byte(target)), 32'(got));
    check_value("rom read databus_oe", 32'(1'b0), 32'(oe));
    check_value("rom read databus_dir", 32'(1'b1), 32'(dir));
    finish_test("rom_read");

    // Save-RAM write in bank 70
    a = {8'h70, 1'b0, 15'($urandom)};
    target = `SAVERAM_BASE + (cart_addr_t'({a[20:16], a[14:0]}) & saveram_mask);
    val = cart_byte_t'($urandom);
    if (val == model_byte(target)) val = ~val;
    partner = model_byte(target ^ 24'h1);
    we_before = we_low_cycles;
    console_cycle(a, 1'b1, val, got, oe, dir);
    wait_we_high();
    check_value("saveram write model", 32'(val), 32'(model_byte(target)));
    check_value("saveram other lane", 32'(partner), 32'(model_byte(target ^ 24'h1)));
    check_value("saveram write strobe", 32'(1'b1), 32'(we_low_cycles > we_before));
    check_value("saveram databus_oe", 32'(1'b0), 32'(oe));
    check_value("saveram databus_dir", 32'(1'b0), 32'(dir));
    finish_test("saveram");

    // Command window stays off the PSRAM
    we_before = we_low_cycles;
    for (int i = 0; i < 16; i++) begin
      cmd_exp[i[3:0]] = cart_byte_t'($urandom);
      console_cycle(`SNESCMD_BASE + cart_addr_t'(i), 1'b1, cmd_exp[i[3:0]], got, oe, dir);
      check_value($sformatf("cmd write %0d oe", i), 32'(1'b0), 32'(oe));
      check_value($sformatf("cmd write %0d dir", i), 32'(1'b0), 32'(dir));
    end
    for (int i = 0; i < 16; i++) begin
      console_cycle(`SNESCMD_BASE + cart_addr_t'(i), 1'b0, 8'h00, got, oe, dir);
      check_value($sformatf("cmd reg %0d", i), 32'(cmd_exp[i[3:0]]), 32'(got));
      check_value($sformatf("cmd reg %0d oe", i), 32'(1'b0), 32'(oe));
      check_value($sformatf("cmd reg %0d dir", i), 32'(1'b1), 32'(dir));
    end
    check_value("cmd psram writes", 32'(we_before), 32'(we_low_cycles));
    finish_test("snescmd");

    // Nothing mapped below 2000 in bank 00
    a = {8'h00, 3'b000, 13'($urandom)};
    console_cycle(a, 1'b0, 8'h00, got, oe, dir);
    check_value("unmapped databus_oe", 32'(1'b1), 32'(oe));
    check_value("unmapped databus_dir", 32'(1'b1), 32'(dir));
    finish_test("unmapped");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+design
design/cart_pkg.sv
design/snes_bus_if.sv
design/snes_bus_sync.sv
design/addr_decode.sv
design/cmd_regs.sv
design/rom_arbiter.sv
design/cart_main.sv
test/psram_model.sv
test/tb_cart_main.sv
